//--- fb_pkg.sv
package fb_pkg;

  // Pixel formats
  typedef logic [23:0] rgb888_t;
  typedef logic [15:0] rgb565_t;

  // Eight RGB565 pixels, lane 0 in the low bits
  typedef logic [127:0] fb_word_t;

  // Word address in 128-bit blocks
  typedef logic [26:0] fb_addr_t;

  // Raster positions
  typedef logic [10:0] hpix_t;
  typedef logic [9:0]  vline_t;

  localparam int PIXELS_PER_WORD = 8;

  typedef enum logic [1:0] {
    PAT_SOLID,
    PAT_CROSS,
    PAT_HRAMP,
    PAT_MIX
  } pattern_e;

  // Scan position handed to the packer
  typedef struct packed {
    logic [7:0] hword;
    vline_t     vline;
    pattern_e   pattern;
  } scan_pos_t;

  // One memory write beat
  typedef struct packed {
    fb_addr_t addr;
    fb_word_t data;
    logic     last;
  } fb_beat_t;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_LOAD,
    CTRL_WAIT_PORT,
    CTRL_DONE
  } ctrl_state_e;

endpackage

//--- fb_scan_control.sv
module fb_scan_control import fb_pkg::*; #(
  parameter int       H_WORDS = 160,
  parameter int       V_LINES = 720,
  parameter fb_addr_t FB_BASE = '0
) (
  input  logic      clk_in,
  input  logic      reset,
  input  logic      frame_req,
  input  pattern_e  pattern_sel,
  output logic      frame_ack,
  output scan_pos_t scan_pos,
  output logic      load,
  output fb_addr_t  beat_addr,
  output logic      beat_last,
  input  logic      port_done
);

  localparam logic [7:0] H_LAST = 8'(H_WORDS - 1);
  localparam vline_t     V_LAST = vline_t'(V_LINES - 1);

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic [7:0]  hword;
  vline_t      vline;
  pattern_e    pattern;
  fb_addr_t    addr;
  logic        at_h_end;
  logic        step;

  assign at_h_end  = (hword == H_LAST);
  assign beat_last = at_h_end && (vline == V_LAST);

  // Counters move once per completed beat
  assign step = (state == CTRL_WAIT_PORT) && port_done;

  always_comb begin
    state_next = state;
    case (state)
      CTRL_IDLE: begin
        if (frame_req) begin
          state_next = CTRL_LOAD;
        end
      end
      CTRL_LOAD: begin
        state_next = CTRL_WAIT_PORT;
      end
      CTRL_WAIT_PORT: begin
        if (port_done) begin
          state_next = beat_last ? CTRL_DONE : CTRL_LOAD;
        end
      end
      CTRL_DONE: begin
        // Hold ack until the host lets go of the request
        if (!frame_req) begin
          state_next = CTRL_IDLE;
        end
      end
      default: state_next = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (reset) begin
      state <= CTRL_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Pattern is fixed for the whole frame
  always_ff @(posedge clk_in) begin
    if (reset) begin
      pattern <= PAT_SOLID;
    end else if ((state == CTRL_IDLE) && frame_req) begin
      pattern <= pattern_sel;
    end
  end

  // Raster counters and running address, wrapping back to frame start
  always_ff @(posedge clk_in) begin
    if (reset) begin
      hword <= '0;
      vline <= '0;
      addr  <= FB_BASE;
    end else if (step) begin
      if (beat_last) begin
        hword <= '0;
        vline <= '0;
        addr  <= FB_BASE;
      end else if (at_h_end) begin
        hword <= '0;
        vline <= vline + 1'b1;
        addr  <= addr + 1'b1;
      end else begin
        hword <= hword + 1'b1;
        addr  <= addr + 1'b1;
      end
    end
  end

  assign load      = (state == CTRL_LOAD);
  assign frame_ack = (state == CTRL_DONE);
  assign beat_addr = addr;

  assign scan_pos.hword   = hword;
  assign scan_pos.vline   = vline;
  assign scan_pos.pattern = pattern;

endmodule

//--- fb_pattern_gen.sv
module fb_pattern_gen import fb_pkg::*; #(
  parameter int H_WORDS = 160,
  parameter int V_LINES = 720
) (
  input  pattern_e pattern,
  input  hpix_t    x,
  input  vline_t   y,
  output rgb888_t  pixel
);

  // Crosshair centre, half the frame in each direction
  localparam hpix_t  X_CENTER = hpix_t'(4 * H_WORDS);
  localparam vline_t Y_CENTER = vline_t'(V_LINES / 2);

  logic [7:0] x_lo;
  logic [7:0] y_lo;
  logic [7:0] mix_sum;
  logic       on_cross;

  assign x_lo     = x[7:0];
  assign y_lo     = y[7:0];
  // 8-bit sum, wraps on overflow
  assign mix_sum  = x_lo + y_lo;
  assign on_cross = (y == Y_CENTER) || (x == X_CENTER);

  always_comb begin
    case (pattern)
      PAT_SOLID: begin
        // Magenta
        pixel = {8'hff, 8'h00, 8'hff};
      end
      PAT_CROSS: begin
        if (on_cross) begin
          pixel = {8'hff, 8'hff, 8'hff};
        end else begin
          pixel = {8'h00, 8'h00, 8'h00};
        end
      end
      PAT_HRAMP: begin
        // Grey level follows the column
        pixel = {x_lo, x_lo, x_lo};
      end
      PAT_MIX: begin
        pixel = {x_lo, y_lo, mix_sum};
      end
      default: begin
        pixel = '0;
      end
    endcase
  end

endmodule

//--- fb_pixel_packer.sv
module fb_pixel_packer import fb_pkg::*; #(
  parameter int H_WORDS = 160,
  parameter int V_LINES = 720
) (
  input  scan_pos_t scan_pos,
  output fb_word_t  word
);

  localparam int LANE_BITS = $bits(rgb565_t);

  // First pixel column of this word
  hpix_t base_x;

  assign base_x = {scan_pos.hword, 3'b000};

  for (genvar lane = 0; lane < PIXELS_PER_WORD; lane++) begin : g_lane
    hpix_t   x;
    rgb888_t pixel;
    rgb565_t px565;

    assign x = base_x + hpix_t'(lane);

    fb_pattern_gen #(
      .H_WORDS(H_WORDS),
      .V_LINES(V_LINES)
    ) i_gen (
      .pattern(scan_pos.pattern),
      .x      (x),
      .y      (scan_pos.vline),
      .pixel  (pixel)
    );

    // Keep the top 5/6/5 bits of each channel
    assign px565 = {pixel[23:19], pixel[15:10], pixel[7:3]};

    assign word[lane*LANE_BITS +: LANE_BITS] = px565;
  end

endmodule

//--- fb_write_port.sv
module fb_write_port import fb_pkg::*; (
  input  logic     clk_in,
  input  logic     reset,
  input  logic     load,
  input  fb_addr_t beat_addr,
  input  logic     beat_last,
  input  fb_word_t word,
  output fb_beat_t mem_beat,
  output logic     mem_req,
  input  logic     mem_ack,
  output logic     port_busy,
  output logic     port_done
);

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_REQ,
    PORT_RELEASE
  } port_state_e;

  port_state_e state;

  assign port_busy = (state != PORT_IDLE);
  assign mem_req   = (state == PORT_REQ);

  // Beat is delivered once ack has dropped after req went low
  assign port_done = (state == PORT_RELEASE) && !mem_ack;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      state <= PORT_IDLE;
    end else begin
      case (state)
        PORT_IDLE: begin
          if (load) begin
            state <= PORT_REQ;
          end
        end
        PORT_REQ: begin
          if (mem_ack) begin
            state <= PORT_RELEASE;
          end
        end
        PORT_RELEASE: begin
          if (!mem_ack) begin
            state <= PORT_IDLE;
          end
        end
        default: state <= PORT_IDLE;
      endcase
    end
  end

  // Beat held steady for the whole exchange
  always_ff @(posedge clk_in) begin
    if (load && !port_busy) begin
      mem_beat.addr <= beat_addr;
      mem_beat.data <= word;
      mem_beat.last <= beat_last;
    end
  end

endmodule

//--- fb_pattern_writer.sv
module fb_pattern_writer import fb_pkg::*; #(
  parameter int       H_WORDS = 160,
  parameter int       V_LINES = 720,
  parameter fb_addr_t FB_BASE = '0
) (
  input  logic     clk_in,
  input  logic     reset,
  input  logic     frame_req,
  input  pattern_e pattern_sel,
  output logic     frame_ack,
  output fb_beat_t mem_beat,
  output logic     mem_req,
  input  logic     mem_ack
);

  scan_pos_t scan_pos;
  fb_word_t  word;
  fb_addr_t  beat_addr;
  logic      beat_last;
  logic      load;
  logic      port_done;
  // Exchange in progress, watched by the bound checker
  logic      port_busy;

  fb_scan_control #(
    .H_WORDS(H_WORDS),
    .V_LINES(V_LINES),
    .FB_BASE(FB_BASE)
  ) i_control (
    .clk_in     (clk_in),
    .reset      (reset),
    .frame_req  (frame_req),
    .pattern_sel(pattern_sel),
    .frame_ack  (frame_ack),
    .scan_pos   (scan_pos),
    .load       (load),
    .beat_addr  (beat_addr),
    .beat_last  (beat_last),
    .port_done  (port_done)
  );

  fb_pixel_packer #(
    .H_WORDS(H_WORDS),
    .V_LINES(V_LINES)
  ) i_packer (
    .scan_pos(scan_pos),
    .word    (word)
  );

  fb_write_port i_port (
    .clk_in   (clk_in),
    .reset    (reset),
    .load     (load),
    .beat_addr(beat_addr),
    .beat_last(beat_last),
    .word     (word),
    .mem_beat (mem_beat),
    .mem_req  (mem_req),
    .mem_ack  (mem_ack),
    .port_busy(port_busy),
    .port_done(port_done)
  );

endmodule

//--- fb_pattern_writer_assertions.sv
module fb_pattern_writer_assertions import fb_pkg::*; #(
  parameter int       H_WORDS = 160,
  parameter int       V_LINES = 720,
  parameter fb_addr_t FB_BASE = '0
) (
  input logic     clk_in,
  input logic     reset,
  input logic     frame_req,
  input pattern_e pattern_sel,
  input logic     frame_ack,
  input fb_beat_t mem_beat,
  input logic     mem_req,
  input logic     mem_ack,
  input logic     port_busy
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam fb_addr_t LAST_ADDR = FB_BASE + fb_addr_t'(H_WORDS * V_LINES - 1);

  int unsigned fail_count = 0;
  logic        req_q;
  logic        ack_q;
  pattern_e    pat_q;
  fb_addr_t    exp_addr;
  logic        delivered;
  logic [1:0]  req_due;
  logic        last_done_q;

  // Expected word rebuilt lane by lane from the beat address
  function automatic fb_word_t expected_word(input fb_addr_t addr, input pattern_e pat);
    int         offset;
    int         h;
    int         v;
    int         x;
    rgb888_t    px;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    fb_word_t   w;
    offset = int'(addr - FB_BASE);
    h = offset % H_WORDS;
    v = offset / H_WORDS;
    w = '0;
    for (int i = 0; i < 8; i++) begin
      x = 8 * h + i;
      case (pat)
        PAT_SOLID: px = 24'hff00ff;
        PAT_CROSS: px = ((v == V_LINES / 2) || (x == 4 * H_WORDS)) ? 24'hffffff : 24'h000000;
        PAT_HRAMP: px = {8'(x), 8'(x), 8'(x)};
        PAT_MIX:   px = {8'(x), 8'(v), 8'(x + v)};
        default:   px = '0;
      endcase
      {r, g, b} = px;
      w[16*i +: 16] = {r[7:3], g[7:2], b[7:3]};
    end
    return w;
  endfunction

  // Beat delivered when ack is seen falling
  assign delivered = ack_q && !mem_ack;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      req_q       <= 1'b0;
      ack_q       <= 1'b0;
      pat_q       <= PAT_SOLID;
      exp_addr    <= FB_BASE;
      req_due     <= '0;
      last_done_q <= 1'b0;
    end else begin
      req_q <= frame_req;
      ack_q <= mem_ack;
      if (frame_req && !req_q) begin
        pat_q <= pattern_sel;
      end
      if (delivered) begin
        exp_addr <= (exp_addr == LAST_ADDR) ? FB_BASE : exp_addr + 1'b1;
      end
      req_due     <= {req_due[0], delivered && !mem_beat.last};
      last_done_q <= delivered && mem_beat.last;
    end
  end

  a_data: assert property (@(posedge clk_in) disable iff (reset)
    mem_req |-> (mem_beat.data == expected_word(mem_beat.addr, pat_q)))
    else begin
      fail_count++;
      $error("[ERROR] %0t: data word wrong at address %0d", $time, mem_beat.addr);
    end

  a_addr: assert property (@(posedge clk_in) disable iff (reset)
    mem_req |-> (mem_beat.addr == exp_addr))
    else begin
      fail_count++;
      $error("[ERROR] %0t: beat address %0d, expected %0d", $time, mem_beat.addr, exp_addr);
    end

  a_last: assert property (@(posedge clk_in) disable iff (reset)
    mem_req |-> (mem_beat.last == (exp_addr == LAST_ADDR)))
    else begin
      fail_count++;
      $error("[ERROR] %0t: last flag wrong at address %0d", $time, mem_beat.addr);
    end

  a_stable: assert property (@(posedge clk_in) disable iff (reset)
    ($past(mem_req) && mem_req) |-> $stable(mem_beat))
    else begin
      fail_count++;
      $error("%0t: beat changed while mem_req was high", $time);
    end

  a_req_rise: assert property (@(posedge clk_in) disable iff (reset)
    $rose(mem_req) |-> !mem_ack)
    else begin
      fail_count++;
      $error("%0t: mem_req rose while mem_ack was high", $time);
    end

  a_req_hold: assert property (@(posedge clk_in) disable iff (reset)
    (mem_req && !mem_ack) |=> mem_req)
    else begin
      fail_count++;
      $error("%0t: mem_req dropped before mem_ack", $time);
    end

  a_req_gap: assert property (@(posedge clk_in) disable iff (reset)
    req_due[1] |-> $rose(mem_req))
    else begin
      fail_count++;
      $error("%0t: next mem_req not 2 cycles after mem_ack fell", $time);
    end

  a_ack_rise: assert property (@(posedge clk_in) disable iff (reset)
    $rose(frame_ack) == last_done_q)
    else begin
      fail_count++;
      $error("%0t: frame_ack not in step with the last beat", $time);
    end

  a_ack_hold: assert property (@(posedge clk_in) disable iff (reset)
    (frame_ack && frame_req) |=> frame_ack)
    else begin
      fail_count++;
      $error("%0t: frame_ack dropped while frame_req was high", $time);
    end

  a_ack_fall: assert property (@(posedge clk_in) disable iff (reset)
    (frame_ack && !frame_req) |=> !frame_ack)
    else begin
      fail_count++;
      $error("%0t: frame_ack stayed high after frame_req fell", $time);
    end

  a_ack_no_req: assert property (@(posedge clk_in) disable iff (reset)
    frame_ack |-> (!mem_req && !port_busy))
    else begin
      fail_count++;
      $error("%0t: memory exchange in flight while frame_ack was high", $time);
    end

  a_reset: assert property (@(posedge clk_in)
    reset |=> (!frame_ack && !mem_req))
    else begin
      fail_count++;
      $error("%0t: frame_ack or mem_req high after reset", $time);
    end

endmodule

bind fb_pattern_writer fb_pattern_writer_assertions #(
  .H_WORDS(H_WORDS),
  .V_LINES(V_LINES),
  .FB_BASE(FB_BASE)
) i_assertions (
  .clk_in     (clk_in),
  .reset      (reset),
  .frame_req  (frame_req),
  .pattern_sel(pattern_sel),
  .frame_ack  (frame_ack),
  .mem_beat   (mem_beat),
  .mem_req    (mem_req),
  .mem_ack    (mem_ack),
  .port_busy  (port_busy)
);

//--- tb_fb_pattern_writer.sv
module tb_fb_pattern_writer import fb_pkg::*; ;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int       H_WORDS     = 4;
  localparam int       V_LINES     = 3;
  localparam fb_addr_t FB_BASE     = 27'd100;
  localparam int       FRAME_BEATS = H_WORDS * V_LINES;
  localparam int       NUM_FRAMES  = 5;
  // Worst case about 14 cycles per beat, plus reset and handshake margin
  localparam int       MAX_CYCLES  = NUM_FRAMES * FRAME_BEATS * 14 + 360;

  logic        clk_in;
  logic        reset;
  logic        frame_req;
  pattern_e    pattern_sel;
  logic        frame_ack;
  fb_beat_t    mem_beat;
  logic        mem_req;
  logic        mem_ack;

  int          error_count = 0;
  int          cycle_count = 0;
  int          beat_count = 0;
  logic        req_seen = 1'b0;
  logic [31:0] rng_state = 32'd40284;

  fb_pattern_writer #(
    .H_WORDS(H_WORDS),
    .V_LINES(V_LINES),
    .FB_BASE(FB_BASE)
  ) i_dut (
    .clk_in     (clk_in),
    .reset      (reset),
    .frame_req  (frame_req),
    .pattern_sel(pattern_sel),
    .frame_ack  (frame_ack),
    .mem_beat   (mem_beat),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack)
  );

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Memory side, random ack delay of 0 to 5 cycles on both edges
  initial begin : memory_responder
    int delay;
    mem_ack <= 1'b0;
    forever begin
      @(posedge clk_in);
      if (mem_req && !mem_ack) begin
        rng_state = xorshift32(rng_state);
        delay = rng_state % 6;
        repeat (delay) @(posedge clk_in);
        mem_ack <= 1'b1;
        do @(posedge clk_in); while (mem_req);
        rng_state = xorshift32(rng_state);
        delay = rng_state % 6;
        repeat (delay) @(posedge clk_in);
        mem_ack <= 1'b0;
      end
    end
  end

  // One beat per rising mem_req
  always @(posedge clk_in) begin
    if (!reset && mem_req && !req_seen) begin
      beat_count <= beat_count + 1;
    end
    req_seen <= mem_req;
  end

  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic run_frame(input pattern_e pat);
    int start_count;
    int beats;
    @(posedge clk_in);
    start_count = beat_count;
    pattern_sel <= pat;
    frame_req   <= 1'b1;
    do @(posedge clk_in); while (!frame_ack);
    beats = beat_count - start_count;
    if (beats != FRAME_BEATS) begin
      $display("[ERROR] %0t: frame %s wrote %0d beats, expected %0d",
               $time, pat.name(), beats, FRAME_BEATS);
      error_count++;
    end
    frame_req <= 1'b0;
    do @(posedge clk_in); while (frame_ack);
  endtask

  initial begin : host
    int assert_errors;
    reset       <= 1'b1;
    frame_req   <= 1'b0;
    pattern_sel <= PAT_SOLID;
    repeat (8) @(posedge clk_in);
    reset <= 1'b0;
    run_frame(PAT_SOLID);
    run_frame(PAT_CROSS);
    run_frame(PAT_HRAMP);
    run_frame(PAT_MIX);
    // Back-to-back repeat, starts over at FB_BASE
    run_frame(PAT_MIX);
    repeat (4) @(posedge clk_in);
    assert_errors = i_dut.i_assertions.fail_count;
    $display("Beat count errors: %0d, assertion failures: %0d", error_count, assert_errors);
    if ((error_count == 0) && (assert_errors == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- compile.f
fb_pkg.sv
fb_scan_control.sv
fb_pattern_gen.sv
fb_pixel_packer.sv
fb_write_port.sv
fb_pattern_writer.sv
fb_pattern_writer_assertions.sv
tb_fb_pattern_writer.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_fb_pattern_writer
FILELIST = compile.f
RUNFLAGS = +verilator+error+limit+1000
LOG      = sim.log
BIN      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
